//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_pdh
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := sim passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/callback_mux.sv
`timescale 1ns/1ps

module callback_mux import pdh_pkg::*; #(
    parameter int ADC_WIDTH = 14,
    parameter int DAC_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  cmd_t                  cmd_i,
    input  data_t                 data_i,
    pdh_cfg_if.reader             cfg,
    input  logic [ADC_WIDTH-1:0]  adc_a_i,
    input  logic [ADC_WIDTH-1:0]  adc_b_i,
    input  coef_t                 adc_a_s_i,
    input  coef_t                 adc_b_s_i,
    input  coef_t                 i_feed_i,
    input  coef_t                 q_feed_i,
    output logic [GPIO_WIDTH-1:0] callback_o
);

    cmd_t                  cmd_q;      // Aligned with the register bank update
    logic [4:0]            sel_q;
    coef_t                 cs_val_w;
    logic [GPIO_WIDTH-1:0] cb_w;
    logic [GPIO_WIDTH-1:0] callback_r;

    // CHECK_SIGNED selector
    always_comb begin
        case (sel_q)
            5'd0:    cs_val_w = adc_a_s_i;
            5'd1:    cs_val_w = adc_b_s_i;
            5'd2:    cs_val_w = cfg.stg_cos;
            5'd3:    cs_val_w = cfg.stg_sin;
            5'd4:    cs_val_w = cfg.live_cos;
            5'd5:    cs_val_w = cfg.live_sin;
            5'd6:    cs_val_w = i_feed_i;
            5'd7:    cs_val_w = q_feed_i;
            default: cs_val_w = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Callback word
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cb_w = '0;
        case (cmd_q)
            CMD_SET_LED:           cb_w[7:0] = cfg.led;
            CMD_SET_DAC:           cb_w[2*DAC_WIDTH-1:0] = {cfg.dac_a, cfg.dac_b};
            CMD_GET_ADC:           cb_w[2*ADC_WIDTH-1:0] = {adc_b_i, adc_a_i};
            CMD_CHECK_SIGNED: begin
                cb_w[20:16] = sel_q;
                cb_w[15:0]  = cs_val_w;
            end
            CMD_SET_ROT_COEFFS:    cb_w[27:0] = {cfg.stg_sin[15:2], cfg.stg_cos[15:2]};
            CMD_COMMIT_ROT_COEFFS: cb_w[27:0] = {q_feed_i[15:2], i_feed_i[15:2]};
            default: ;                         // Dropped codes stay all zero
        endcase
        if (cmd_q <= CMD_COMMIT_ROT_COEFFS) begin
            cb_w[GPIO_WIDTH-1 -: 4] = cmd_q;
        end
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            cmd_q      <= CMD_IDLE;
            sel_q      <= '0;
            callback_r <= '0;
        end else begin
            cmd_q      <= cmd_i;
            sel_q      <= data_i[4:0];
            callback_r <= cb_w;
        end
    end

    assign callback_o = callback_r;

endmodule

//--- src/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode import pdh_pkg::*; #(
    parameter int SYNC_STAGES = 3
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [GPIO_WIDTH-1:0] gpio_i,
    output cmd_t                  cmd_o,
    output data_t                 data_o,
    output logic                  new_cmd_o
);

    logic [GPIO_WIDTH-1:0] sync_r [SYNC_STAGES];
    logic [GPIO_WIDTH-1:0] word_r;
    logic                  strobe_w;
    logic                  strobe_d_r;
    logic                  strobe_edge_w;
    logic                  new_cmd_r;

    // Strobe as seen at the end of the chain
    assign strobe_w      = sync_r[SYNC_STAGES-1][STROBE_BIT];
    assign strobe_edge_w = strobe_w & ~strobe_d_r;

    //////////////////////////////////////////////////////////////////////
    // Synchronizer and word latch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_r[i] <= '0;
            end
            strobe_d_r <= 1'b0;
            word_r     <= '0;     // Decodes as IDLE
            new_cmd_r  <= 1'b0;
        end else begin
            sync_r[0] <= gpio_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_r[i] <= sync_r[i-1];
            end
            strobe_d_r <= strobe_w;
            new_cmd_r  <= strobe_edge_w;
            if (strobe_edge_w) begin
                word_r <= sync_r[SYNC_STAGES-1];
            end
        end
    end

    // Field split, held until the next strobe
    assign cmd_o     = cmd_t'(word_r[CMD_MSB:CMD_LSB]);
    assign data_o    = word_r[DATA_WIDTH-1:0];
    assign new_cmd_o = new_cmd_r;   // High with the first cycle of a new word

endmodule

//--- src/cmd_execute.sv
`timescale 1ns/1ps

module cmd_execute import pdh_pkg::*; #(
    parameter int DAC_WIDTH = 14
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  cmd_t                 cmd_i,
    input  data_t                data_i,
    pdh_cfg_if.owner             cfg,
    output logic [DAC_WIDTH-1:0] dac_dat_o,
    output logic                 dac_sel_o
);

    localparam logic [DAC_WIDTH-1:0] DAC_RST = DAC_WIDTH'(DAC_MID);
    localparam int DAC_CH_BIT  = DAC_WIDTH;   // Selects channel B
    localparam int ROT_SIN_BIT = 16;          // Selects the sin coefficient

    logic dac_sel_r;

    //////////////////////////////////////////////////////////////////////
    // Register bank
    //////////////////////////////////////////////////////////////////////

    // The latched command is applied every cycle until the next one
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            cfg.led      <= '0;
            cfg.dac_a    <= DAC_RST;
            cfg.dac_b    <= DAC_RST;
            cfg.stg_cos  <= COEF_ONE;
            cfg.stg_sin  <= '0;
            cfg.live_cos <= COEF_ONE;
            cfg.live_sin <= '0;
        end else begin
            case (cmd_i)
                CMD_SET_LED: begin
                    cfg.led <= data_i[7:0];
                end

                CMD_SET_DAC: begin
                    if (data_i[DAC_CH_BIT]) begin
                        cfg.dac_b <= data_i[DAC_WIDTH-1:0];
                    end else begin
                        cfg.dac_a <= data_i[DAC_WIDTH-1:0];
                    end
                end

                CMD_SET_ROT_COEFFS: begin
                    if (data_i[ROT_SIN_BIT]) begin
                        cfg.stg_sin <= coef_t'(data_i[15:0]);
                    end else begin
                        cfg.stg_cos <= coef_t'(data_i[15:0]);
                    end
                end

                CMD_COMMIT_ROT_COEFFS: begin
                    cfg.live_cos <= cfg.stg_cos;
                    cfg.live_sin <= cfg.stg_sin;
                end

                default: ;   // IDLE, readbacks and dropped codes
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // DAC interleave
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac_sel_r <= 1'b0;
        end else begin
            dac_sel_r <= ~dac_sel_r;
        end
    end

    assign dac_sel_o = dac_sel_r;
    assign dac_dat_o = dac_sel_r ? cfg.dac_b : cfg.dac_a;   // B on high select

endmodule

//--- src/iq_rotator.sv
`timescale 1ns/1ps

module iq_rotator import pdh_pkg::*; #(
    parameter int ADC_WIDTH = 14
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [ADC_WIDTH-1:0] adc_a_i,
    input  logic [ADC_WIDTH-1:0] adc_b_i,
    pdh_cfg_if.reader            cfg,
    output coef_t                adc_a_s_o,
    output coef_t                adc_b_s_o,
    output coef_t                i_feed_o,
    output coef_t                q_feed_o
);

    // Half of full scale
    localparam logic [ADC_WIDTH:0] ADC_OFFSET = (ADC_WIDTH + 1)'(2 ** (ADC_WIDTH - 1));

    logic signed [ADC_WIDTH:0] a_diff_w, b_diff_w;
    coef_t                     adc_a_s_r, adc_b_s_r;
    logic signed [31:0]        ca_w, sb_w, sa_w, cb_w;
    logic signed [32:0]        i_full_w, q_full_w;
    logic signed [31:0]        i_sat_w, q_sat_w;
    logic signed [31:0]        i_shift_w, q_shift_w;
    coef_t                     i_feed_r, q_feed_r;

    // Offset binary to signed, inverted polarity
    assign a_diff_w = $signed(ADC_OFFSET) - $signed({1'b0, adc_a_i});
    assign b_diff_w = $signed(ADC_OFFSET) - $signed({1'b0, adc_b_i});

    //////////////////////////////////////////////////////////////////////
    // Rotation by the live coefficients
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ca_w = cfg.live_cos * adc_a_s_r;
        sb_w = cfg.live_sin * adc_b_s_r;
        sa_w = cfg.live_sin * adc_a_s_r;
        cb_w = cfg.live_cos * adc_b_s_r;
        i_full_w = ca_w - sb_w;
        q_full_w = sa_w + cb_w;
        // Clamp when bits 32 and 31 disagree
        i_sat_w = (i_full_w[32] ^ i_full_w[31]) ?
                  {i_full_w[32], {31{~i_full_w[32]}}} : i_full_w[31:0];
        q_sat_w = (q_full_w[32] ^ q_full_w[31]) ?
                  {q_full_w[32], {31{~q_full_w[32]}}} : q_full_w[31:0];
        i_shift_w = i_sat_w >>> ROT_SHIFT;
        q_shift_w = q_sat_w >>> ROT_SHIFT;
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            adc_a_s_r <= '0;
            adc_b_s_r <= '0;
            i_feed_r  <= '0;
            q_feed_r  <= '0;
        end else begin
            adc_a_s_r <= a_diff_w;             // Sign extends to 16 bits
            adc_b_s_r <= b_diff_w;
            i_feed_r  <= i_shift_w[15:0];
            q_feed_r  <= q_shift_w[15:0];
        end
    end

    assign adc_a_s_o = adc_a_s_r;
    assign adc_b_s_o = adc_b_s_r;
    assign i_feed_o  = i_feed_r;
    assign q_feed_o  = q_feed_r;

endmodule

//--- src/pdh_cfg_if.sv
`timescale 1ns/1ps

interface pdh_cfg_if import pdh_pkg::*; #(
    parameter int DAC_WIDTH = 14
) ();

    logic [7:0]           led;
    logic [DAC_WIDTH-1:0] dac_a;
    logic [DAC_WIDTH-1:0] dac_b;
    coef_t                stg_cos;    // Staged, not yet in use
    coef_t                stg_sin;
    coef_t                live_cos;   // Feeding the rotator
    coef_t                live_sin;

    modport owner (
        output led, dac_a, dac_b,
        output stg_cos, stg_sin, live_cos, live_sin
    );

    modport reader (
        input led, dac_a, dac_b,
        input stg_cos, stg_sin, live_cos, live_sin
    );

endinterface

//--- src/pdh_pkg.sv
package pdh_pkg;

    ////////////////////////////////////////////////////////////////////
    // GPIO word layout
    ////////////////////////////////////////////////////////////////////

    localparam int GPIO_WIDTH = 32;   // Command and callback words
    localparam int STROBE_BIT = 30;
    localparam int CMD_MSB    = 29;
    localparam int CMD_LSB    = 26;
    localparam int DATA_WIDTH = 26;   // Bits 25:0

    typedef enum logic [3:0] {
        CMD_IDLE              = 4'd0,
        CMD_SET_LED           = 4'd1,
        CMD_SET_DAC           = 4'd2,
        CMD_GET_ADC           = 4'd3,
        CMD_CHECK_SIGNED      = 4'd4,
        CMD_SET_ROT_COEFFS    = 4'd5,
        CMD_COMMIT_ROT_COEFFS = 4'd6
    } cmd_t;

    // Reserved codes, no effect and zero callback
    //   7  GET_FRAME
    //   8  SET_KP
    //   9  SET_KD
    //   10 SET_KI
    //   11 SET_DEC
    //   12 SET_SP
    //   13 SET_ALPHA_SAT_EN

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Coefficients, signed samples and I/Q feeds
    typedef logic signed [15:0] coef_t;

    ////////////////////////////////////////////////////////////////////
    // Reset values and scaling
    ////////////////////////////////////////////////////////////////////

    localparam coef_t COEF_ONE = 16'sh7FFF;   // Close to +1.0 in Q15
    localparam int    DAC_MID  = 'h2000;       // Mid-scale
    localparam int    ROT_SHIFT = 15;

endpackage

//--- src/pdh_top.sv
`timescale 1ns/1ps

module pdh_top import pdh_pkg::*; #(
    parameter int ADC_WIDTH = 14,
    parameter int DAC_WIDTH = 14
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic [ADC_WIDTH-1:0]  adc_dat_a_i,
    input  logic [ADC_WIDTH-1:0]  adc_dat_b_i,
    input  logic [GPIO_WIDTH-1:0] axi_from_ps_i,
    output logic [GPIO_WIDTH-1:0] axi_to_ps_o,
    output logic [7:0]            led_o,
    output logic [DAC_WIDTH-1:0]  dac_dat_o,
    output logic                  dac_sel_o
);

    cmd_t  cmd_w;
    data_t data_w;
    logic  new_cmd_w;
    coef_t adc_a_s_w, adc_b_s_w;
    coef_t i_feed_w, q_feed_w;

    pdh_cfg_if #(.DAC_WIDTH(DAC_WIDTH)) u_cfg ();

    cmd_decode #(.SYNC_STAGES(3)) u_decode (
        .clk       (clk),
        .rst_i     (rst_i),
        .gpio_i    (axi_from_ps_i),
        .cmd_o     (cmd_w),
        .data_o    (data_w),
        .new_cmd_o (new_cmd_w)
    );

    cmd_execute #(.DAC_WIDTH(DAC_WIDTH)) u_execute (
        .clk       (clk),
        .rst_i     (rst_i),
        .cmd_i     (cmd_w),
        .data_i    (data_w),
        .cfg       (u_cfg.owner),
        .dac_dat_o (dac_dat_o),
        .dac_sel_o (dac_sel_o)
    );

    iq_rotator #(.ADC_WIDTH(ADC_WIDTH)) u_rotator (
        .clk       (clk),
        .rst_i     (rst_i),
        .adc_a_i   (adc_dat_a_i),
        .adc_b_i   (adc_dat_b_i),
        .cfg       (u_cfg.reader),
        .adc_a_s_o (adc_a_s_w),
        .adc_b_s_o (adc_b_s_w),
        .i_feed_o  (i_feed_w),
        .q_feed_o  (q_feed_w)
    );

    callback_mux #(.ADC_WIDTH(ADC_WIDTH), .DAC_WIDTH(DAC_WIDTH)) u_result (
        .clk        (clk),
        .rst_i      (rst_i),
        .cmd_i      (cmd_w),
        .data_i     (data_w),
        .cfg        (u_cfg.reader),
        .adc_a_i    (adc_dat_a_i),
        .adc_b_i    (adc_dat_b_i),
        .adc_a_s_i  (adc_a_s_w),
        .adc_b_s_i  (adc_b_s_w),
        .i_feed_i   (i_feed_w),
        .q_feed_i   (q_feed_w),
        .callback_o (axi_to_ps_o)
    );

    assign led_o = u_cfg.led;

endmodule

//--- test/pdh_assertions.sv
`timescale 1ns/1ps

module pdh_assertions import pdh_pkg::*; #(
    parameter int DAC_WIDTH = 14
) (
    input logic                  clk,
    input logic                  rst_i,
    input logic                  new_cmd_i,
    input logic [GPIO_WIDTH-1:0] callback_i,
    input logic                  dac_sel_i,
    input logic [DAC_WIDTH-1:0]  dac_dat_i
);

    int unsigned          fail_count = 0;   // Failed assertions so far
    logic [DAC_WIDTH-1:0] dac_fall_r;       // DAC bus at the falling edge

    always_ff @(negedge clk) begin
        dac_fall_r <= dac_dat_i;
    end

    // Select flips on every edge once out of reset
    sel_toggle: assert property (@(posedge clk) disable iff (rst_i)
        !$past(rst_i) |-> dac_sel_i != $past(dac_sel_i))
    else begin
        fail_count++;
        $error("dac_sel_o held its value across a clock edge");
    end

    // Command field of the callback moves two edges after the new word
    cb_timing: assert property (@(posedge clk) disable iff (rst_i)
        $changed(callback_i[GPIO_WIDTH-1 -: 4]) |-> $past(new_cmd_i, 2))
    else begin
        fail_count++;
        $error("callback command field changed outside its slot");
    end

    // DAC bus holds from the falling edge up to the next rising edge
    dac_half_period: assert property (@(posedge clk) disable iff (rst_i)
        dac_dat_i == dac_fall_r)
    else begin
        fail_count++;
        $error("dac_dat_o changed in the second half of the clock period");
    end

endmodule

bind pdh_top pdh_assertions #(.DAC_WIDTH(DAC_WIDTH)) u_checks (
    .clk        (clk),
    .rst_i      (rst_i),
    .new_cmd_i  (new_cmd_w),
    .callback_i (axi_to_ps_o),
    .dac_sel_i  (dac_sel_o),
    .dac_dat_i  (dac_dat_o)
);

//--- test/tb_pdh.sv
`timescale 1ns/1ps

module tb_pdh import pdh_pkg::*;;

    localparam int ADC_WIDTH    = 14;
    localparam int DAC_WIDTH    = 14;
    localparam int ADC_OFFSET   = 2 ** (ADC_WIDTH - 1);
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CMDS     = 19;
    localparam int LIMIT_CYCLES = RESET_CYCLES + NUM_CMDS * 12 + 64;
    localparam longint SAT_MAX  = (longint'(1) <<< 31) - 1;
    localparam longint SAT_MIN  = -(longint'(1) <<< 31);

    logic                  clk;
    logic                  rst_i;
    logic [ADC_WIDTH-1:0]  adc_dat_a;
    logic [ADC_WIDTH-1:0]  adc_dat_b;
    logic [GPIO_WIDTH-1:0] axi_from_ps;
    logic [GPIO_WIDTH-1:0] axi_to_ps;
    logic [7:0]            led;
    logic [DAC_WIDTH-1:0]  dac_dat;
    logic                  dac_sel;
    logic [15:0]           lfsr_q = 16'd68;

    pdh_top #(.ADC_WIDTH(ADC_WIDTH), .DAC_WIDTH(DAC_WIDTH)) u_pdh_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .adc_dat_a_i   (adc_dat_a),
        .adc_dat_b_i   (adc_dat_b),
        .axi_from_ps_i (axi_from_ps),
        .axi_to_ps_o   (axi_to_ps),
        .led_o         (led),
        .dac_dat_o     (dac_dat),
        .dac_sel_o     (dac_sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers and reference model
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb    = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v     = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic coef_t to_signed_ref(input logic [ADC_WIDTH-1:0] raw);
        int v;
        v = ADC_OFFSET - int'(raw);
        return coef_t'(v);
    endfunction

    function automatic coef_t rotate_ref(input coef_t c, input coef_t s, input coef_t x,
                                         input coef_t y, input bit want_q);
        longint full;
        if (want_q) begin
            full = longint'(s) * longint'(x) + longint'(c) * longint'(y);
        end else begin
            full = longint'(c) * longint'(x) - longint'(s) * longint'(y);
        end
        if (full > SAT_MAX) begin
            full = SAT_MAX;
        end else if (full < SAT_MIN) begin
            full = SAT_MIN;
        end
        full = full >>> ROT_SHIFT;
        return coef_t'(full[15:0]);
    endfunction

    task automatic report_failure();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else begin
            $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, act);
            report_failure();
        end
    endtask

    // Word with strobe low, then high, then let it settle
    task automatic send_cmd(input logic [3:0] code, input data_t data);
        @(negedge clk);
        axi_from_ps = {2'b00, code, data};
        @(negedge clk);
        axi_from_ps = {2'b01, code, data};
        repeat (8) @(negedge clk);
    endtask

    task automatic check_dac_pair(input string name, input logic [DAC_WIDTH-1:0] exp_a,
                                  input logic [DAC_WIDTH-1:0] exp_b);
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            check_value(name, dac_sel ? exp_b : exp_a, dac_dat);
        end
    endtask

    task automatic check_signed(input logic [4:0] sel, input coef_t exp, input string name);
        data_t d;
        d      = rand_bits(DATA_WIDTH);
        d[4:0] = sel;
        send_cmd(CMD_CHECK_SIGNED, d);
        check_value(name, {CMD_CHECK_SIGNED, 7'd0, sel, exp}, axi_to_ps);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        data_t                d;
        logic [7:0]           led_exp;
        logic [DAC_WIDTH-1:0] dac_a_exp, dac_b_exp;
        logic [ADC_WIDTH-1:0] raw_a, raw_b;
        coef_t                a_s, b_s, sin_exp, cos_exp, i_exp, q_exp;
        rst_i       = 1'b1;
        axi_from_ps = '0;
        adc_dat_a   = '0;
        adc_dat_b   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_i = 1'b0;

        check_value("reset_callback", '0, axi_to_ps);
        send_cmd(CMD_IDLE, '0);
        check_value("idle_callback", '0, axi_to_ps);
        check_value("reset_led", '0, led);
        check_dac_pair("reset_dac", DAC_WIDTH'(DAC_MID), DAC_WIDTH'(DAC_MID));

        d       = rand_bits(DATA_WIDTH);
        led_exp = d[7:0];
        send_cmd(CMD_SET_LED, d);
        check_value("set_led_port", led_exp, led);
        check_value("set_led_callback", {CMD_SET_LED, 20'd0, led_exp}, axi_to_ps);

        d            = rand_bits(DATA_WIDTH);
        d[DAC_WIDTH] = 1'b0;   // Channel A
        dac_a_exp    = d[DAC_WIDTH-1:0];
        send_cmd(CMD_SET_DAC, d);
        check_value("set_dac_a_callback", {CMD_SET_DAC, dac_a_exp, DAC_WIDTH'(DAC_MID)},
                    axi_to_ps);
        d            = rand_bits(DATA_WIDTH);
        d[DAC_WIDTH] = 1'b1;
        dac_b_exp    = d[DAC_WIDTH-1:0];
        send_cmd(CMD_SET_DAC, d);
        check_value("set_dac_b_callback", {CMD_SET_DAC, dac_a_exp, dac_b_exp}, axi_to_ps);
        check_dac_pair("set_dac_interleave", dac_a_exp, dac_b_exp);

        // Samples change while SET_DAC is current and then stay put
        raw_a     = rand_bits(ADC_WIDTH);
        raw_b     = rand_bits(ADC_WIDTH);
        adc_dat_a = raw_a;
        adc_dat_b = raw_b;
        a_s       = to_signed_ref(raw_a);
        b_s       = to_signed_ref(raw_b);
        send_cmd(CMD_GET_ADC, rand_bits(DATA_WIDTH));
        check_value("get_adc_callback", {CMD_GET_ADC, raw_b, raw_a}, axi_to_ps);
        check_signed(5'd0, a_s, "check_signed_adc_a");
        check_signed(5'd1, b_s, "check_signed_adc_b");

        d       = rand_bits(DATA_WIDTH);
        d[16]   = 1'b1;
        sin_exp = d[15:0];
        send_cmd(CMD_SET_ROT_COEFFS, d);
        check_value("set_sin_callback", {CMD_SET_ROT_COEFFS, sin_exp[15:2], COEF_ONE[15:2]},
                    axi_to_ps);
        d       = rand_bits(DATA_WIDTH);
        d[16]   = 1'b0;
        cos_exp = d[15:0];
        send_cmd(CMD_SET_ROT_COEFFS, d);
        check_value("set_cos_callback", {CMD_SET_ROT_COEFFS, sin_exp[15:2], cos_exp[15:2]},
                    axi_to_ps);
        check_signed(5'd2, cos_exp, "staged_cos");
        check_signed(5'd3, sin_exp, "staged_sin");
        check_signed(5'd4, COEF_ONE, "live_cos_before_commit");
        check_signed(5'd5, '0, "live_sin_before_commit");

        i_exp = rotate_ref(cos_exp, sin_exp, a_s, b_s, 1'b0);
        q_exp = rotate_ref(cos_exp, sin_exp, a_s, b_s, 1'b1);
        send_cmd(CMD_COMMIT_ROT_COEFFS, rand_bits(DATA_WIDTH));
        check_value("commit_callback", {CMD_COMMIT_ROT_COEFFS, q_exp[15:2], i_exp[15:2]},
                    axi_to_ps);
        check_signed(5'd4, cos_exp, "live_cos_after_commit");
        check_signed(5'd5, sin_exp, "live_sin_after_commit");
        check_signed(5'd6, i_exp, "i_feed");
        check_signed(5'd7, q_exp, "q_feed");

        // SET_KP belongs to the PID path, which is not in this design
        send_cmd(4'd8, rand_bits(DATA_WIDTH));
        check_value("dropped_callback", '0, axi_to_ps);
        check_value("dropped_led", led_exp, led);
        check_dac_pair("dropped_dac", dac_a_exp, dac_b_exp);

        if (u_pdh_top.u_checks.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", u_pdh_top.u_checks.fail_count);
            report_failure();
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog expired, the run timed out after %0d cycles", LIMIT_CYCLES);
        report_failure();
    end

endmodule

//--- verilog.f
src/pdh_pkg.sv
src/pdh_cfg_if.sv
src/cmd_decode.sv
src/cmd_execute.sv
src/iq_rotator.sv
src/callback_mux.sv
src/pdh_top.sv
test/pdh_assertions.sv
test/tb_pdh.sv
